// File: all.f
hw/exu_pkg.sv
hw/exu_mul.sv
hw/exu_div.sv
hw/exu_muldiv_ctrl.sv
hw/exu_wb_buffer.sv
hw/exu_muldiv.sv
verification/exu_muldiv_properties.sv
verification/tb_exu_muldiv.sv

// File: Bender.yml
package:
  name: exu_muldiv

sources:
  # design, package first
  - files:
      - hw/exu_pkg.sv
      - hw/exu_mul.sv
      - hw/exu_div.sv
      - hw/exu_muldiv_ctrl.sv
      - hw/exu_wb_buffer.sv
      - hw/exu_muldiv.sv

  # simulation only
  - target: test
    files:
      - verification/exu_muldiv_properties.sv
      - verification/tb_exu_muldiv.sv

// File: verification/tb_exu_muldiv.sv
// *************************************
// self-checking testbench for exu_muldiv, one request in flight at a time
// run length is capped by a cycle limit scaled to the number of operations
// *************************************

`timescale 1ns/1ps

module tb_exu_muldiv import exu_pkg::*; ();

    // operation counts per test
    localparam int N_CORNER   = 5;
    localparam int N_MUL_RAND = 60;
    localparam int N_DIV_RAND = 40;
    localparam int N_SPECIAL  = 6;
    localparam int N_BP       = 4;
    localparam int N_TRAFFIC  = 200;
    localparam int N_OPS      = 1 + 4 * (N_CORNER * N_CORNER + N_MUL_RAND)
                                + 4 * N_DIV_RAND + N_SPECIAL + N_BP + N_TRAFFIC;
    localparam int CYCLE_LIMIT  = N_OPS * 40 + 500;
    localparam int HOLD_CYCLES  = 60;
    // one operation in flight plus a full buffer drains well within this
    localparam int DRAIN_LIMIT  = 120;

    logic       clk;
    logic       arst_n_i;
    logic       req_muldiv_i;
    muldiv_op_e muldiv_op_i;
    xlen_t      op1_i;
    xlen_t      op2_i;
    reg_addr_t  reg_waddr_i;
    commit_id_t commit_id_i;
    logic       mul_div_accepted_o;
    logic       reg_we_o;
    xlen_t      reg_wdata_o;
    reg_addr_t  reg_waddr_o;
    commit_id_t commit_id_o;
    logic       wb_ready_i;

    // scoreboard, one entry per accepted request
    xlen_t      exp_data_q[$];
    reg_addr_t  exp_addr_q[$];
    commit_id_t exp_cid_q[$];

    int         pass_count;
    int         fail_count;
    int         accept_count;
    int         cycle_count;
    commit_id_t next_cid;
    logic       rand_ready;

    xlen_t corners [N_CORNER] = '{32'h0, 32'h1, 32'hffffffff, 32'h80000000, 32'h7fffffff};

    exu_muldiv exu_muldiv_i (
        .clk               (clk),
        .arst_n_i          (arst_n_i),
        .req_muldiv_i      (req_muldiv_i),
        .muldiv_op_i       (muldiv_op_i),
        .op1_i             (op1_i),
        .op2_i             (op2_i),
        .reg_waddr_i       (reg_waddr_i),
        .commit_id_i       (commit_id_i),
        .mul_div_accepted_o(mul_div_accepted_o),
        .reg_we_o          (reg_we_o),
        .reg_wdata_o       (reg_wdata_o),
        .reg_waddr_o       (reg_waddr_o),
        .commit_id_o       (commit_id_o),
        .wb_ready_i        (wb_ready_i)
    );

    initial begin
        clk = 1'b0;
        forever #10 clk = ~clk;
    end

    // RISC-V M semantics on 64-bit intermediates
    function automatic xlen_t expected_result(input muldiv_op_e op, input xlen_t a,
                                              input xlen_t b);
        logic signed [63:0] sa;
        logic signed [63:0] sb;
        logic signed [63:0] ub_s;
        logic signed [63:0] wide;
        logic [63:0]        ua;
        logic [63:0]        ub;
        sa   = {{32{a[31]}}, a};
        sb   = {{32{b[31]}}, b};
        ua   = {32'h0, a};
        ub   = {32'h0, b};
        ub_s = ub;
        case (op)
            OP_MUL:    wide = sa * sb;
            OP_MULH:   wide = (sa * sb) >>> 32;
            OP_MULHSU: wide = (sa * ub_s) >>> 32;
            OP_MULHU:  wide = (ua * ub) >> 32;
            OP_DIV:    wide = (b == 0) ? -64'sd1 : sa / sb;
            OP_DIVU:   wide = (b == 0) ? -64'sd1 : ua / ub;
            OP_REM:    wide = (b == 0) ? sa : sa % sb;
            default:   wide = (b == 0) ? ua : ua % ub;
        endcase
        // signed overflow keeps the dividend as quotient, zero remainder
        if (a == 32'h80000000 && b == 32'hffffffff) begin
            if (op == OP_DIV) begin
                wide = sa;
            end else if (op == OP_REM) begin
                wide = 0;
            end
        end
        return wide[31:0];
    endfunction

    task automatic check_value(input string what, input logic [31:0] got,
                               input logic [31:0] exp);
        if (got !== exp) begin
            $display("[ERROR] %0t: %s is %h, expected %h", $time, what, got, exp);
            fail_count++;
        end else begin
            pass_count++;
        end
    endtask

    task automatic raise_req(input muldiv_op_e op, input xlen_t a, input xlen_t b);
        @(negedge clk);
        req_muldiv_i = 1'b1;
        muldiv_op_i  = op;
        op1_i        = a;
        op2_i        = b;
        reg_waddr_i  = reg_addr_t'($urandom_range(1, 31));
        commit_id_i  = next_cid;
        next_cid     = next_cid + 1'b1;
    endtask

    task automatic finish_req();
        do begin
            @(posedge clk);
        end while (!mul_div_accepted_o);
        @(negedge clk);
        req_muldiv_i = 1'b0;
    endtask

    task automatic send_op(input muldiv_op_e op, input xlen_t a, input xlen_t b);
        raise_req(op, a, b);
        finish_req();
    endtask

    // bounded wait for the scoreboard to empty
    task automatic wait_drain();
        int waited;
        waited = 0;
        while ((exp_data_q.size() != 0) && (waited < DRAIN_LIMIT)) begin
            @(negedge clk);
            waited++;
        end
    endtask

    task automatic report_test(input string name, input int fails_before);
        $display("test %s done, %0d errors", name, fail_count - fails_before);
    endtask

    // record expected results as requests are accepted
    always @(posedge clk) begin
        if (arst_n_i && req_muldiv_i && mul_div_accepted_o) begin
            exp_data_q.push_back(expected_result(muldiv_op_i, op1_i, op2_i));
            exp_addr_q.push_back(reg_waddr_i);
            exp_cid_q.push_back(commit_id_i);
            accept_count++;
        end
    end

    always @(posedge clk) begin : compare_wb
        xlen_t      exp_data;
        reg_addr_t  exp_addr;
        commit_id_t exp_cid;
        if (arst_n_i && reg_we_o && wb_ready_i) begin
            if (exp_data_q.size() == 0) begin
                $display("writeback at %0t with no result outstanding", $time);
                fail_count++;
            end else begin
                exp_data = exp_data_q.pop_front();
                exp_addr = exp_addr_q.pop_front();
                exp_cid  = exp_cid_q.pop_front();
                check_value($sformatf("wdata of tag %0d", exp_cid), reg_wdata_o, exp_data);
                check_value("waddr", reg_waddr_o, exp_addr);
                check_value("commit id", commit_id_o, exp_cid);
            end
        end
    end

    // random writeback back-pressure during traffic
    always @(negedge clk) begin
        if (rand_ready) begin
            wb_ready_i = 1'($urandom_range(0, 1));
        end
    end

    initial begin
        cycle_count = 0;
        while (cycle_count < CYCLE_LIMIT) begin
            @(posedge clk);
            cycle_count++;
        end
        $display("timeout, run did not finish within %0d cycles", CYCLE_LIMIT);
        $display("Simulation failed");
        $finish;
    end

    initial begin
        muldiv_op_e op;
        xlen_t      a;
        xlen_t      b;
        xlen_t      held_data;
        reg_addr_t  held_addr;
        commit_id_t held_cid;
        logic       held_ok;
        int         fails_before;
        int         accept_base;

        void'($urandom(32'h78a4a5fd));
        arst_n_i     = 1'b0;
        req_muldiv_i = 1'b0;
        muldiv_op_i  = OP_MUL;
        op1_i        = '0;
        op2_i        = '0;
        reg_waddr_i  = '0;
        commit_id_i  = '0;
        wb_ready_i   = 1'b1;
        rand_ready   = 1'b0;
        next_cid     = '0;
        pass_count   = 0;
        fail_count   = 0;
        accept_count = 0;

        repeat (2) @(posedge clk);
        @(negedge clk);
        arst_n_i = 1'b1;

        // 1: idle after reset, first request taken at once
        fails_before = fail_count;
        check_value("reg_we_o after reset", reg_we_o, 1'b0);
        raise_req(OP_MUL, 32'd7, 32'd6);
        @(posedge clk);
        check_value("accept in request cycle", mul_div_accepted_o, 1'b1);
        @(negedge clk);
        req_muldiv_i = 1'b0;
        wait_drain();
        report_test("reset state", fails_before);

        // 2: multiply variants, corners then random pairs
        fails_before = fail_count;
        for (int v = 0; v < 4; v++) begin
            op = muldiv_op_e'(v);
            for (int i = 0; i < N_CORNER; i++) begin
                for (int j = 0; j < N_CORNER; j++) begin
                    send_op(op, corners[i], corners[j]);
                end
            end
            for (int i = 0; i < N_MUL_RAND; i++) begin
                send_op(op, $urandom(), $urandom());
            end
        end
        wait_drain();
        report_test("multiply variants", fails_before);

        // 3: divide and remainder, divisors of mixed size and sign
        fails_before = fail_count;
        for (int v = 4; v < 8; v++) begin
            op = muldiv_op_e'(v);
            for (int i = 0; i < N_DIV_RAND; i++) begin
                a = $urandom();
                b = $urandom() >> $urandom_range(0, 31);
                if ($urandom_range(0, 1)) begin
                    b = -b;
                end
                if (b == 0) begin
                    b = 32'd3;
                end
                send_op(op, a, b);
            end
        end
        wait_drain();
        report_test("divide variants", fails_before);

        // 4: zero divisor and signed overflow
        fails_before = fail_count;
        for (int v = 4; v < 8; v++) begin
            send_op(muldiv_op_e'(v), $urandom(), 32'h0);
        end
        send_op(OP_DIV, 32'h80000000, 32'hffffffff);
        send_op(OP_REM, 32'h80000000, 32'hffffffff);
        wait_drain();
        report_test("special division", fails_before);

        // 5: buffer fills, third result stalls the controller
        fails_before = fail_count;
        @(negedge clk);
        wb_ready_i  = 1'b0;
        accept_base = accept_count;
        for (int i = 0; i < 3; i++) begin
            send_op(muldiv_op_e'($urandom_range(0, 7)), $urandom(), $urandom() | 32'h1);
        end
        raise_req(OP_MULHU, $urandom(), $urandom());
        @(posedge clk);
        held_data = reg_wdata_o;
        held_addr = reg_waddr_o;
        held_cid  = commit_id_o;
        held_ok   = reg_we_o;
        for (int i = 0; i < HOLD_CYCLES; i++) begin
            @(posedge clk);
            if (!reg_we_o || reg_wdata_o !== held_data || reg_waddr_o !== held_addr
                || commit_id_o !== held_cid) begin
                held_ok = 1'b0;
            end
        end
        check_value("accepts while stalled", accept_count - accept_base, 3);
        check_value("outputs held while stalled", held_ok, 1'b1);
        @(negedge clk);
        wb_ready_i = 1'b1;
        finish_req();
        wait_drain();
        report_test("back-pressure", fails_before);

        // 6: mixed traffic with random gaps and ready
        fails_before = fail_count;
        rand_ready   = 1'b1;
        for (int i = 0; i < N_TRAFFIC; i++) begin
            repeat ($urandom_range(0, 3)) @(negedge clk);
            send_op(muldiv_op_e'($urandom_range(0, 7)), $urandom(), $urandom());
        end
        @(negedge clk);
        rand_ready = 1'b0;
        wb_ready_i = 1'b1;
        wait_drain();
        report_test("random traffic", fails_before);

        repeat (4) @(negedge clk);
        if (exp_data_q.size() != 0) begin
            $display("%0d expected results were never written back", exp_data_q.size());
            fail_count++;
        end
        $display("checks passed %0d, failed %0d", pass_count, fail_count);
        if (fail_count == 0) begin
            $display("Simulation completed successfully");
        end else begin
            $display("Simulation failed");
        end
        $finish;
    end

endmodule

// File: verification/exu_muldiv_properties.sv
// *************************************
// handshake assertions, bound into every exu_muldiv instance
// *************************************

`timescale 1ns/1ps

module exu_muldiv_properties import exu_pkg::*; (
    input logic       clk,
    input logic       arst_n_i,
    input logic       req_muldiv_i,
    input logic       mul_div_accepted_o,
    input logic       reg_we_o,
    input xlen_t      reg_wdata_o,
    input reg_addr_t  reg_waddr_o,
    input commit_id_t commit_id_o,
    input logic       wb_ready_i
);

    // no acceptance without a request
    accept_needs_req: assert property (@(posedge clk) disable iff (!arst_n_i)
        mul_div_accepted_o |-> req_muldiv_i)
        else $error("mul_div_accepted_o high without req_muldiv_i");

    // stalled writeback keeps its entry on the outputs
    wb_hold: assert property (@(posedge clk) disable iff (!arst_n_i)
        (reg_we_o && !wb_ready_i) |=> (reg_we_o && $stable(reg_wdata_o)
            && $stable(reg_waddr_o) && $stable(commit_id_o)))
        else $error("writeback outputs changed while wb_ready_i was low");

    // buffer empty right after reset
    we_low_after_reset: assert property (@(posedge clk)
        $rose(arst_n_i) |-> !reg_we_o)
        else $error("reg_we_o high in the first cycle after reset");

endmodule

bind exu_muldiv exu_muldiv_properties exu_muldiv_properties_i (
    .clk               (clk),
    .arst_n_i          (arst_n_i),
    .req_muldiv_i      (req_muldiv_i),
    .mul_div_accepted_o(mul_div_accepted_o),
    .reg_we_o          (reg_we_o),
    .reg_wdata_o       (reg_wdata_o),
    .reg_waddr_o       (reg_waddr_o),
    .commit_id_o       (commit_id_o),
    .wb_ready_i        (wb_ready_i)
);

// File: hw/exu_muldiv.sv
// *************************************
// multiply/divide path, request/accepted in, we/ready out
// *************************************

`timescale 1ns/1ps

module exu_muldiv import exu_pkg::*; (
    input  logic       clk,
    input  logic       arst_n_i,
    input  logic       req_muldiv_i,
    input  muldiv_op_e muldiv_op_i,
    input  xlen_t      op1_i,
    input  xlen_t      op2_i,
    input  reg_addr_t  reg_waddr_i,
    input  commit_id_t commit_id_i,
    output logic       mul_div_accepted_o,
    output logic       reg_we_o,
    output xlen_t      reg_wdata_o,
    output reg_addr_t  reg_waddr_o,
    output commit_id_t commit_id_o,
    input  logic       wb_ready_i
);
    logic       mul_start;
    logic       div_start;
    muldiv_op_e eng_op;
    xlen_t      eng_op1;
    xlen_t      eng_op2;
    logic       mul_valid;
    xlen_t      mul_result;
    logic       div_valid;
    xlen_t      div_result;
    logic       push;
    xlen_t      push_wdata;
    reg_addr_t  push_waddr;
    commit_id_t push_commit_id;
    logic       wb_full;

    exu_muldiv_ctrl u_muldiv_ctrl (
        .clk               (clk),
        .arst_n_i          (arst_n_i),
        .req_muldiv_i      (req_muldiv_i),
        .muldiv_op_i       (muldiv_op_i),
        .op1_i             (op1_i),
        .op2_i             (op2_i),
        .reg_waddr_i       (reg_waddr_i),
        .commit_id_i       (commit_id_i),
        .mul_div_accepted_o(mul_div_accepted_o),
        .mul_start_o       (mul_start),
        .div_start_o       (div_start),
        .eng_op_o          (eng_op),
        .eng_op1_o         (eng_op1),
        .eng_op2_o         (eng_op2),
        .mul_valid_i       (mul_valid),
        .mul_result_i      (mul_result),
        .div_valid_i       (div_valid),
        .div_result_i      (div_result),
        .push_o            (push),
        .push_wdata_o      (push_wdata),
        .push_waddr_o      (push_waddr),
        .push_commit_id_o  (push_commit_id),
        .full_i            (wb_full)
    );

    // both engines share the registered operands
    exu_mul u_mul (
        .clk           (clk),
        .arst_n_i      (arst_n_i),
        .start_i       (mul_start),
        .op_i          (eng_op),
        .multiplicand_i(eng_op1),
        .multiplier_i  (eng_op2),
        .result_o      (mul_result),
        .valid_o       (mul_valid)
    );

    exu_div u_div (
        .clk       (clk),
        .arst_n_i  (arst_n_i),
        .start_i   (div_start),
        .op_i      (eng_op),
        .dividend_i(eng_op1),
        .divisor_i (eng_op2),
        .result_o  (div_result),
        .valid_o   (div_valid)
    );

    exu_wb_buffer u_wb_buffer (
        .clk        (clk),
        .arst_n_i   (arst_n_i),
        .push_i     (push),
        .wdata_i    (push_wdata),
        .waddr_i    (push_waddr),
        .commit_id_i(push_commit_id),
        .full_o     (wb_full),
        .reg_we_o   (reg_we_o),
        .reg_wdata_o(reg_wdata_o),
        .reg_waddr_o(reg_waddr_o),
        .commit_id_o(commit_id_o),
        .wb_ready_i (wb_ready_i)
    );

endmodule

// File: hw/exu_wb_buffer.sv
// *************************************
// in-order result buffer of WB_DEPTH entries
// full_o drops when a pop frees an entry in the same cycle
// *************************************

`timescale 1ns/1ps

module exu_wb_buffer import exu_pkg::*; (
    input  logic       clk,
    input  logic       arst_n_i,
    input  logic       push_i,
    input  xlen_t      wdata_i,
    input  reg_addr_t  waddr_i,
    input  commit_id_t commit_id_i,
    output logic       full_o,
    output logic       reg_we_o,
    output xlen_t      reg_wdata_o,
    output reg_addr_t  reg_waddr_o,
    output commit_id_t commit_id_o,
    input  logic       wb_ready_i
);
    xlen_t      data_q  [WB_DEPTH];
    reg_addr_t  waddr_q [WB_DEPTH];
    commit_id_t cid_q   [WB_DEPTH];

    logic [$clog2(WB_DEPTH)-1:0]   wr_ptr_q;
    logic [$clog2(WB_DEPTH)-1:0]   rd_ptr_q;
    logic [$clog2(WB_DEPTH+1)-1:0] count_q;
    logic                          pop;

    assign pop    = reg_we_o && wb_ready_i;
    assign full_o = (count_q == WB_DEPTH) && !pop;

    always_ff @(posedge clk or negedge arst_n_i) begin
        if (!arst_n_i) begin
            wr_ptr_q <= '0;
            rd_ptr_q <= '0;
            count_q  <= '0;
        end else begin
            if (push_i) begin
                wr_ptr_q <= (wr_ptr_q == WB_DEPTH - 1) ? '0 : wr_ptr_q + 1'b1;
            end
            if (pop) begin
                rd_ptr_q <= (rd_ptr_q == WB_DEPTH - 1) ? '0 : rd_ptr_q + 1'b1;
            end
            if (push_i && !pop) begin
                count_q <= count_q + 1'b1;
            end else if (pop && !push_i) begin
                count_q <= count_q - 1'b1;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (push_i) begin
            data_q[wr_ptr_q]  <= wdata_i;
            waddr_q[wr_ptr_q] <= waddr_i;
            cid_q[wr_ptr_q]   <= commit_id_i;
        end
    end

    // oldest entry is always on the outputs
    assign reg_we_o    = (count_q != '0);
    assign reg_wdata_o = data_q[rd_ptr_q];
    assign reg_waddr_o = waddr_q[rd_ptr_q];
    assign commit_id_o = cid_q[rd_ptr_q];

endmodule

// File: hw/exu_muldiv_ctrl.sv
// *************************************
// one operation in flight, request fields held until accepted
// result waits in HOLD while the writeback buffer is full
// *************************************

`timescale 1ns/1ps

module exu_muldiv_ctrl import exu_pkg::*; (
    input  logic       clk,
    input  logic       arst_n_i,
    input  logic       req_muldiv_i,
    input  muldiv_op_e muldiv_op_i,
    input  xlen_t      op1_i,
    input  xlen_t      op2_i,
    input  reg_addr_t  reg_waddr_i,
    input  commit_id_t commit_id_i,
    output logic       mul_div_accepted_o,
    output logic       mul_start_o,
    output logic       div_start_o,
    output muldiv_op_e eng_op_o,
    output xlen_t      eng_op1_o,
    output xlen_t      eng_op2_o,
    input  logic       mul_valid_i,
    input  xlen_t      mul_result_i,
    input  logic       div_valid_i,
    input  xlen_t      div_result_i,
    output logic       push_o,
    output xlen_t      push_wdata_o,
    output reg_addr_t  push_waddr_o,
    output commit_id_t push_commit_id_o,
    input  logic       full_i
);
    typedef enum logic [1:0] {
        ST_IDLE,
        ST_ISSUE,
        ST_BUSY,
        ST_HOLD
    } state_e;

    state_e     state_q;
    state_e     state_d;
    muldiv_op_e op_q;
    xlen_t      op1_q;
    xlen_t      op2_q;
    reg_addr_t  waddr_q;
    commit_id_t cid_q;
    xlen_t      res_q;
    logic       accept;
    logic       is_mul;
    logic       eng_valid;

    assign accept = req_muldiv_i && (state_q == ST_IDLE);

    // top bit of the op picks the engine
    assign is_mul    = ~op_q[2];
    assign eng_valid = is_mul ? mul_valid_i : div_valid_i;

    always_comb begin
        state_d = state_q;
        unique case (state_q)
            ST_IDLE: begin
                if (accept) begin
                    state_d = ST_ISSUE;
                end
            end
            ST_ISSUE: begin
                state_d = ST_BUSY;
            end
            ST_BUSY: begin
                if (eng_valid) begin
                    state_d = ST_HOLD;
                end
            end
            ST_HOLD: begin
                if (!full_i) begin
                    state_d = ST_IDLE;
                end
            end
            default: begin
                state_d = ST_IDLE;
            end
        endcase
    end

    always_ff @(posedge clk or negedge arst_n_i) begin
        if (!arst_n_i) begin
            state_q <= ST_IDLE;
        end else begin
            state_q <= state_d;
        end
    end

    // request fields, then the engine result
    always_ff @(posedge clk) begin
        if (accept) begin
            op_q    <= muldiv_op_i;
            op1_q   <= op1_i;
            op2_q   <= op2_i;
            waddr_q <= reg_waddr_i;
            cid_q   <= commit_id_i;
        end
        if ((state_q == ST_BUSY) && eng_valid) begin
            res_q <= is_mul ? mul_result_i : div_result_i;
        end
    end

    assign mul_div_accepted_o = accept;

    // single-cycle start right after acceptance
    assign mul_start_o = (state_q == ST_ISSUE) && is_mul;
    assign div_start_o = (state_q == ST_ISSUE) && !is_mul;
    assign eng_op_o    = op_q;
    assign eng_op1_o   = op1_q;
    assign eng_op2_o   = op2_q;

    assign push_o           = (state_q == ST_HOLD) && !full_i;
    assign push_wdata_o     = res_q;
    assign push_waddr_o     = waddr_q;
    assign push_commit_id_o = cid_q;

endmodule

// File: hw/exu_div.sv
// *************************************
// restoring divider, valid_o 33 cycles after start_i
// divide by zero and signed overflow answer 1 cycle after start_i
// *************************************

`timescale 1ns/1ps

module exu_div import exu_pkg::*; (
    input  logic       clk,
    input  logic       arst_n_i,
    input  logic       start_i,
    input  muldiv_op_e op_i,
    input  xlen_t      dividend_i,
    input  xlen_t      divisor_i,
    output xlen_t      result_o,
    output logic       valid_o
);
    xlen_t                   rem_q;
    xlen_t                   quo_q;
    xlen_t                   divisor_q;
    xlen_t                   result_q;
    logic                    q_neg_q;
    logic                    r_neg_q;
    logic                    rem_sel_q;
    logic                    busy_q;
    logic                    fix_q;
    logic                    valid_q;
    logic [$clog2(XLEN)-1:0] step_q;

    logic  is_signed;
    logic  is_rem;
    logic  a_neg;
    logic  b_neg;
    xlen_t a_mag;
    xlen_t b_mag;
    logic  div_zero;
    logic  overflow;
    xlen_t special;
    xlen_t quo_fix;
    xlen_t rem_fix;

    // shift one dividend bit into the partial remainder, restore on borrow
    function automatic logic [2*XLEN-1:0] div_step(input xlen_t rem,
                                                   input xlen_t quo,
                                                   input xlen_t dvs);
        logic [XLEN:0] shifted;
        logic [XLEN:0] diff;
        shifted = {rem, quo[XLEN-1]};
        diff    = shifted - {1'b0, dvs};
        if (diff[XLEN]) begin
            return {shifted[XLEN-1:0], quo[XLEN-2:0], 1'b0};
        end
        return {diff[XLEN-1:0], quo[XLEN-2:0], 1'b1};
    endfunction

    always_comb begin
        is_signed = (op_i == OP_DIV) || (op_i == OP_REM);
        is_rem    = (op_i == OP_REM) || (op_i == OP_REMU);
        a_neg     = is_signed && dividend_i[XLEN-1];
        b_neg     = is_signed && divisor_i[XLEN-1];
        a_mag     = a_neg ? -dividend_i : dividend_i;
        b_mag     = b_neg ? -divisor_i : divisor_i;
        div_zero  = (divisor_i == '0);
        overflow  = is_signed && (dividend_i == {1'b1, {(XLEN-1){1'b0}}})
                    && (divisor_i == '1);
        if (div_zero) begin
            special = is_rem ? dividend_i : '1;
        end else begin
            special = is_rem ? '0 : dividend_i;
        end
    end

    // quotient follows the operand sign xor, remainder the dividend
    assign quo_fix = q_neg_q ? -quo_q : quo_q;
    assign rem_fix = r_neg_q ? -rem_q : rem_q;

    always_ff @(posedge clk or negedge arst_n_i) begin
        if (!arst_n_i) begin
            busy_q  <= 1'b0;
            fix_q   <= 1'b0;
            valid_q <= 1'b0;
            step_q  <= '0;
        end else begin
            valid_q <= 1'b0;
            if (start_i) begin
                if (div_zero || overflow) begin
                    valid_q <= 1'b1;
                end else begin
                    busy_q <= 1'b1;
                    step_q <= 1;
                end
            end else if (busy_q) begin
                step_q <= step_q + 1'b1;
                if (step_q == XLEN - 1) begin
                    busy_q <= 1'b0;
                    fix_q  <= 1'b1;
                end
            end else if (fix_q) begin
                fix_q   <= 1'b0;
                valid_q <= 1'b1;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (start_i) begin
            {rem_q, quo_q} <= div_step('0, a_mag, b_mag);
            divisor_q      <= b_mag;
            q_neg_q        <= a_neg ^ b_neg;
            r_neg_q        <= a_neg;
            rem_sel_q      <= is_rem;
            result_q       <= special;
        end else if (busy_q) begin
            {rem_q, quo_q} <= div_step(rem_q, quo_q, divisor_q);
        end else if (fix_q) begin
            result_q <= rem_sel_q ? rem_fix : quo_fix;
        end
    end

    assign result_o = result_q;
    assign valid_o  = valid_q;

endmodule

// File: hw/exu_mul.sv
// *************************************
// iterative multiplier, valid_o 32 cycles after start_i
// start_i must not be raised while an operation is running
// *************************************

`timescale 1ns/1ps

module exu_mul import exu_pkg::*; (
    input  logic       clk,
    input  logic       arst_n_i,
    input  logic       start_i,
    input  muldiv_op_e op_i,
    input  xlen_t      multiplicand_i,
    input  xlen_t      multiplier_i,
    output xlen_t      result_o,
    output logic       valid_o
);
    logic [2*XLEN-1:0]       acc_q;
    logic [2*XLEN-1:0]       product;
    xlen_t                   mcand_q;
    logic                    neg_q;
    logic                    low_q;
    logic                    busy_q;
    logic                    valid_q;
    logic [$clog2(XLEN)-1:0] step_q;

    logic  a_signed;
    logic  b_signed;
    logic  a_neg;
    logic  b_neg;
    xlen_t a_mag;
    xlen_t b_mag;

    // one add-and-shift step, multiplier bits sit in the low half
    function automatic logic [2*XLEN-1:0] mul_step(input logic [2*XLEN-1:0] acc,
                                                   input xlen_t mcand);
        logic [XLEN:0] sum;
        sum = {1'b0, acc[2*XLEN-1:XLEN]} + (acc[0] ? {1'b0, mcand} : {(XLEN+1){1'b0}});
        return {sum, acc[XLEN-1:1]};
    endfunction

    // operand signedness per variant, MUL only needs the low word
    always_comb begin
        a_signed = (op_i != OP_MULHU);
        b_signed = (op_i == OP_MUL) || (op_i == OP_MULH);
        a_neg    = a_signed && multiplicand_i[XLEN-1];
        b_neg    = b_signed && multiplier_i[XLEN-1];
        a_mag    = a_neg ? -multiplicand_i : multiplicand_i;
        b_mag    = b_neg ? -multiplier_i : multiplier_i;
    end

    // first step is done while loading
    always_ff @(posedge clk or negedge arst_n_i) begin
        if (!arst_n_i) begin
            busy_q  <= 1'b0;
            valid_q <= 1'b0;
            step_q  <= '0;
        end else begin
            valid_q <= 1'b0;
            if (start_i) begin
                busy_q <= 1'b1;
                step_q <= 1;
            end else if (busy_q) begin
                step_q <= step_q + 1'b1;
                if (step_q == XLEN - 1) begin
                    busy_q  <= 1'b0;
                    valid_q <= 1'b1;
                end
            end
        end
    end

    always_ff @(posedge clk) begin
        if (start_i) begin
            acc_q   <= mul_step({{XLEN{1'b0}}, b_mag}, a_mag);
            mcand_q <= a_mag;
            neg_q   <= a_neg ^ b_neg;
            low_q   <= (op_i == OP_MUL);
        end else if (busy_q) begin
            acc_q <= mul_step(acc_q, mcand_q);
        end
    end

    // sign fix on the finished magnitude product
    assign product  = neg_q ? -acc_q : acc_q;
    assign result_o = low_q ? product[XLEN-1:0] : product[2*XLEN-1:XLEN];
    assign valid_o  = valid_q;

endmodule

// File: hw/exu_pkg.sv
// *************************************
// widths and operation encoding shared by the muldiv path
// multiply ops keep the top bit of muldiv_op_e clear
// *************************************

package exu_pkg;

    // data and tag widths
    localparam int XLEN        = 32;
    localparam int REG_ADDR_W  = 5;
    localparam int COMMIT_ID_W = 3;

    // entries in the writeback buffer
    localparam int WB_DEPTH = 2;

    // operand or result word
    typedef logic [XLEN-1:0] xlen_t;

    // destination register index
    typedef logic [REG_ADDR_W-1:0] reg_addr_t;

    // in-order commit tag
    typedef logic [COMMIT_ID_W-1:0] commit_id_t;

    // M-extension operations
    // bit 2 clear means multiplier, set means divider
    typedef enum logic [2:0] {
        OP_MUL    = 3'd0,
        OP_MULH   = 3'd1,
        OP_MULHSU = 3'd2,
        OP_MULHU  = 3'd3,
        OP_DIV    = 3'd4,
        OP_DIVU   = 3'd5,
        OP_REM    = 3'd6,
        OP_REMU   = 3'd7
    } muldiv_op_e;

endpackage
